//--- hw/tri_pkg.sv
package tri_pkg;

    // one RAM word for a coordinate, an index or a sid
    typedef logic [31:0] word_t;

    // shader id where zero marks the end of a load phase
    typedef logic [31:0] sid_t;

    typedef struct packed {
        word_t z;
        word_t y;
        word_t x;
    } vertex_t;

    // index record carries sid and vertex indices 2, 1, 0
    // vertex record carries a nonzero flag and z, y, x
    typedef struct packed {
        sid_t  tag;
        word_t w2;
        word_t w1;
        word_t w0;
    } mc_beat_t;

    typedef struct packed {
        sid_t    sid;
        vertex_t v2;
        vertex_t v1;
        vertex_t v0;
    } triangle_t;

    typedef enum logic [1:0] {
        load_idle,
        load_index,
        load_vertex,
        load_done
    } load_state_e;

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_rd0,
        fetch_rd1,
        fetch_rd2,
        fetch_rd3,
        fetch_drain
    } fetch_state_e;

endpackage

//--- hw/tri_ram.sv
`timescale 1ns/10ps

module tri_ram #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] q
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // registered read returns the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

//--- hw/load_addr_counter.sv
`timescale 1ns/10ps

module load_addr_counter #(
    parameter int NUM_TRIANGLE = 64,
    localparam int ID_WIDTH = $clog2(NUM_TRIANGLE),
    localparam int ADDR_WIDTH = ID_WIDTH + 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  step,
    input  logic                  latch_count,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic [ID_WIDTH:0]     tri_count
);

    // spare top bit so a completely full store still counts right
    logic [ADDR_WIDTH:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // four index words per triangle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tri_count <= '0;
        end else if (latch_count) begin
            tri_count <= cnt[ADDR_WIDTH:2];
        end
    end

    assign addr = cnt[ADDR_WIDTH-1:0];

endmodule

//--- hw/tri_store.sv
`timescale 1ns/10ps

module tri_store #(
    parameter int NUM_TRIANGLE = 64,
    localparam int ID_WIDTH = $clog2(NUM_TRIANGLE),
    localparam int ADDR_WIDTH = ID_WIDTH + 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  loading,
    input  logic                  ld_we_index,
    input  logic                  ld_we_vertex,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    input  tri_pkg::word_t        ld_word,
    input  tri_pkg::vertex_t      ld_vertex,
    input  logic [ADDR_WIDTH-1:0] fetch_addr,
    output tri_pkg::word_t        index_q,
    output tri_pkg::vertex_t      vertex_q
);

    logic [ADDR_WIDTH-1:0] index_addr;
    logic [ADDR_WIDTH-1:0] vertex_addr;
    logic                  we_index;
    logic                  we_vertex;

    // the loader owns both address buses during a load
    assign index_addr  = loading ? ld_addr : fetch_addr;
    // on fetch the vertex RAMs follow the index word just read
    assign vertex_addr = loading ? ld_addr : index_q[ADDR_WIDTH-1:0];

    // no writes while reset is held
    assign we_index  = ld_we_index & rst_n;
    assign we_vertex = ld_we_vertex & rst_n;

    tri_ram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH($bits(index_q))) u_index_ram (
        .clk  (clk),
        .we   (we_index),
        .addr (index_addr),
        .data (ld_word),
        .q    (index_q)
    );

    tri_ram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH($bits(vertex_q.x))) u_x_ram (
        .clk  (clk),
        .we   (we_vertex),
        .addr (vertex_addr),
        .data (ld_vertex.x),
        .q    (vertex_q.x)
    );

    tri_ram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH($bits(vertex_q.y))) u_y_ram (
        .clk  (clk),
        .we   (we_vertex),
        .addr (vertex_addr),
        .data (ld_vertex.y),
        .q    (vertex_q.y)
    );

    tri_ram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH($bits(vertex_q.z))) u_z_ram (
        .clk  (clk),
        .we   (we_vertex),
        .addr (vertex_addr),
        .data (ld_vertex.z),
        .q    (vertex_q.z)
    );

endmodule

//--- hw/tri_load_fsm.sv
`timescale 1ns/10ps

module tri_load_fsm #(
    parameter int NUM_TRIANGLE = 64,
    localparam int ID_WIDTH = $clog2(NUM_TRIANGLE),
    localparam int ADDR_WIDTH = ID_WIDTH + 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tri_pkg::mc_beat_t     mc_beat,
    input  logic                  we_mc,
    input  logic                  done_mc,
    output logic                  rdy_mc,
    output logic                  loading,
    output logic                  ld_we_index,
    output logic                  ld_we_vertex,
    output tri_pkg::word_t        ld_word,
    output tri_pkg::vertex_t      ld_vertex,
    output logic [ADDR_WIDTH-1:0] ld_addr,
    output logic [ID_WIDTH:0]     tri_count
);

    import tri_pkg::*;

    load_state_e state;
    load_state_e state_nx;
    mc_beat_t    beat_q;
    logic [1:0]  sub_cnt;
    logic        writing;
    logic        accept;
    logic        zero_tag;
    logic        start_rec;
    logic        clear;
    logic        latch_count;

    assign accept   = we_mc & rdy_mc;
    assign zero_tag = (mc_beat.tag == '0);
    // low for the four cycles an index record is written out
    assign rdy_mc   = ~writing;
    assign loading  = (state != load_idle);

    assign ld_we_index = writing;
    assign ld_vertex   = '{z: mc_beat.w2, y: mc_beat.w1, x: mc_beat.w0};

    always_comb begin
        state_nx     = state;
        clear        = 1'b0;
        latch_count  = 1'b0;
        start_rec    = 1'b0;
        ld_we_vertex = 1'b0;
        case (state)
            load_idle: begin
                // hold the address at zero until the first beat
                clear = 1'b1;
                if (accept) begin
                    start_rec   = !zero_tag;
                    latch_count = zero_tag;
                    state_nx    = zero_tag ? load_vertex : load_index;
                end
            end
            load_index: begin
                if (accept && zero_tag) begin
                    // whole records written so far become the count
                    latch_count = 1'b1;
                    clear       = 1'b1;
                    state_nx    = load_vertex;
                end else if (accept) begin
                    start_rec = 1'b1;
                end
            end
            load_vertex: begin
                if (accept && zero_tag) begin
                    state_nx = load_done;
                end else if (accept) begin
                    ld_we_vertex = 1'b1;
                end
            end
            default: begin
                if (done_mc) begin
                    state_nx = load_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= load_idle;
            writing <= 1'b0;
            sub_cnt <= '0;
        end else begin
            state <= state_nx;
            if (start_rec) begin
                writing <= 1'b1;
                sub_cnt <= '0;
            end else if (writing) begin
                sub_cnt <= sub_cnt + 1'b1;
                if (sub_cnt == 2'd3) begin
                    writing <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= mc_beat;
        end
    end

    // w0, w1, w2 then the sid
    always_comb begin
        case (sub_cnt)
            2'd0:    ld_word = beat_q.w0;
            2'd1:    ld_word = beat_q.w1;
            2'd2:    ld_word = beat_q.w2;
            default: ld_word = beat_q.tag;
        endcase
    end

    load_addr_counter #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_addr_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .step        (writing | ld_we_vertex),
        .latch_count (latch_count),
        .addr        (ld_addr),
        .tri_count   (tri_count)
    );

endmodule

//--- hw/tri_fetch_fsm.sv
`timescale 1ns/10ps

module tri_fetch_fsm #(
    parameter int NUM_TRIANGLE = 64,
    localparam int ID_WIDTH = $clog2(NUM_TRIANGLE),
    localparam int ADDR_WIDTH = ID_WIDTH + 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  re_ic,
    input  logic [ID_WIDTH-1:0]   tri_id,
    input  logic [ID_WIDTH:0]     tri_count,
    input  logic                  loading,
    output logic [ADDR_WIDTH-1:0] fetch_addr,
    output logic                  cap_v0,
    output logic                  cap_v1,
    output logic                  cap_v2_sid,
    output logic                  commit_fill,
    output logic                  commit_direct,
    output logic                  rdy_ic,
    output logic                  not_valid_ic
);

    import tri_pkg::*;

    fetch_state_e        state;
    fetch_state_e        state_nx;
    logic [ID_WIDTH-1:0] tag_id;
    logic [ID_WIDTH-1:0] tag_id_nx;
    logic                tag_valid;
    logic                tag_valid_nx;
    logic                fill_done;
    logic                fill_done_nx;
    logic                demand;
    logic                demand_nx;
    logic                tag_match;
    logic                bad_req;
    logic                hit;
    logic                busy_hit;
    logic                next_ok;
    logic [1:0]          word_sel;

    assign bad_req   = re_ic && !({1'b0, tri_id} < tri_count);
    assign tag_match = tag_valid && (tag_id == tri_id);
    // prefetched triangle sits complete in the fill register
    assign hit       = re_ic && !bad_req && tag_match && fill_done;
    // the fill for this id is still on its way
    assign busy_hit  = re_ic && !bad_req && tag_match && !fill_done && (state != fetch_idle);
    assign next_ok   = ({1'b0, tag_id} + 1'b1) < tri_count;

    assign fetch_addr    = {tag_id, word_sel};
    assign commit_fill   = hit;
    assign commit_direct = (state == fetch_drain) && (demand || busy_hit);

    always_comb begin
        state_nx     = state;
        tag_id_nx    = tag_id;
        tag_valid_nx = tag_valid;
        fill_done_nx = fill_done;
        demand_nx    = demand;
        word_sel     = 2'd0;
        cap_v0       = 1'b0;
        cap_v1       = 1'b0;
        cap_v2_sid   = 1'b0;
        case (state)
            fetch_rd0: begin
                state_nx = fetch_rd1;
            end
            fetch_rd1: begin
                word_sel = 2'd1;
                state_nx = fetch_rd2;
            end
            fetch_rd2: begin
                word_sel = 2'd2;
                cap_v0   = 1'b1;
                state_nx = fetch_rd3;
            end
            fetch_rd3: begin
                word_sel = 2'd3;
                cap_v1   = 1'b1;
                state_nx = fetch_drain;
            end
            fetch_drain: begin
                cap_v2_sid = 1'b1;
                if (commit_direct) begin
                    // walk on to the next id once answered
                    demand_nx    = 1'b0;
                    tag_id_nx    = tag_id + 1'b1;
                    tag_valid_nx = next_ok;
                    state_nx     = next_ok ? fetch_rd0 : fetch_idle;
                end else begin
                    fill_done_nx = 1'b1;
                    state_nx     = fetch_idle;
                end
            end
            default: begin
                state_nx = fetch_idle;
            end
        endcase

        // a new request overrides the running sequence
        if (loading) begin
            state_nx     = fetch_idle;
            tag_valid_nx = 1'b0;
            demand_nx    = 1'b0;
        end else if (bad_req) begin
            state_nx  = fetch_idle;
            demand_nx = 1'b0;
            if (state != fetch_idle) begin
                tag_valid_nx = 1'b0;
            end
        end else if (hit) begin
            demand_nx    = 1'b0;
            fill_done_nx = 1'b0;
            tag_id_nx    = tag_id + 1'b1;
            tag_valid_nx = next_ok;
            state_nx     = next_ok ? fetch_rd0 : fetch_idle;
        end else if (busy_hit) begin
            if (state != fetch_drain) begin
                demand_nx = 1'b1;
            end
        end else if (re_ic) begin
            // a miss or abort starts over with the requested id
            tag_id_nx    = tri_id;
            tag_valid_nx = 1'b1;
            fill_done_nx = 1'b0;
            demand_nx    = 1'b1;
            state_nx     = fetch_rd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= fetch_idle;
            tag_id       <= '0;
            tag_valid    <= 1'b0;
            fill_done    <= 1'b0;
            demand       <= 1'b0;
            rdy_ic       <= 1'b0;
            not_valid_ic <= 1'b0;
        end else begin
            state        <= state_nx;
            tag_id       <= tag_id_nx;
            tag_valid    <= tag_valid_nx;
            fill_done    <= fill_done_nx;
            demand       <= demand_nx;
            rdy_ic       <= commit_fill | commit_direct;
            not_valid_ic <= bad_req;
        end
    end

endmodule

//--- hw/tri_out_buffer.sv
`timescale 1ns/10ps

module tri_out_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  tri_pkg::word_t     index_q,
    input  tri_pkg::vertex_t   vertex_q,
    input  logic               cap_v0,
    input  logic               cap_v1,
    input  logic               cap_v2_sid,
    input  logic               commit_fill,
    input  logic               commit_direct,
    output tri_pkg::triangle_t triangle_ic
);

    import tri_pkg::*;

    triangle_t fill_q;

    // fill register is built up part by part as the RAM reads return
    always_ff @(posedge clk) begin
        if (cap_v0) begin
            fill_q.v0 <= vertex_q;
        end
        if (cap_v1) begin
            fill_q.v1 <= vertex_q;
        end
        if (cap_v2_sid) begin
            fill_q.v2  <= vertex_q;
            fill_q.sid <= index_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            triangle_ic <= '0;
        end else if (commit_fill) begin
            triangle_ic <= fill_q;
        end else if (commit_direct) begin
            // v2 and sid are on the RAM outputs this cycle
            triangle_ic <= '{sid: index_q, v2: vertex_q, v1: fill_q.v1, v0: fill_q.v0};
        end
    end

endmodule

//--- hw/tri_mem_top.sv
`timescale 1ns/10ps

module tri_mem_top #(
    parameter int NUM_TRIANGLE = 64,
    localparam int ID_WIDTH = $clog2(NUM_TRIANGLE),
    localparam int ADDR_WIDTH = ID_WIDTH + 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  tri_pkg::mc_beat_t   mc_beat,
    input  logic                we_mc,
    input  logic                done_mc,
    output logic                rdy_mc,
    input  logic                re_ic,
    input  logic [ID_WIDTH-1:0] tri_id,
    output tri_pkg::triangle_t  triangle_ic,
    output logic                rdy_ic,
    output logic                not_valid_ic
);

    import tri_pkg::*;

    logic                  loading;
    logic                  ld_we_index;
    logic                  ld_we_vertex;
    word_t                 ld_word;
    vertex_t               ld_vertex;
    logic [ADDR_WIDTH-1:0] ld_addr;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic [ID_WIDTH:0]     tri_count;
    word_t                 index_q;
    vertex_t               vertex_q;
    logic                  cap_v0;
    logic                  cap_v1;
    logic                  cap_v2_sid;
    logic                  commit_fill;
    logic                  commit_direct;

    tri_load_fsm #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_load (
        .clk (clk), .rst_n (rst_n), .mc_beat (mc_beat), .we_mc (we_mc), .done_mc (done_mc),
        .rdy_mc (rdy_mc), .loading (loading), .ld_we_index (ld_we_index),
        .ld_we_vertex (ld_we_vertex), .ld_word (ld_word), .ld_vertex (ld_vertex),
        .ld_addr (ld_addr), .tri_count (tri_count)
    );

    tri_fetch_fsm #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_fetch (
        .clk (clk), .rst_n (rst_n), .re_ic (re_ic), .tri_id (tri_id), .tri_count (tri_count),
        .loading (loading), .fetch_addr (fetch_addr), .cap_v0 (cap_v0), .cap_v1 (cap_v1),
        .cap_v2_sid (cap_v2_sid), .commit_fill (commit_fill), .commit_direct (commit_direct),
        .rdy_ic (rdy_ic), .not_valid_ic (not_valid_ic)
    );

    tri_store #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_store (
        .clk (clk), .rst_n (rst_n), .loading (loading), .ld_we_index (ld_we_index),
        .ld_we_vertex (ld_we_vertex), .ld_addr (ld_addr), .ld_word (ld_word),
        .ld_vertex (ld_vertex), .fetch_addr (fetch_addr), .index_q (index_q),
        .vertex_q (vertex_q)
    );

    tri_out_buffer u_out (
        .clk (clk), .rst_n (rst_n), .index_q (index_q), .vertex_q (vertex_q),
        .cap_v0 (cap_v0), .cap_v1 (cap_v1), .cap_v2_sid (cap_v2_sid),
        .commit_fill (commit_fill), .commit_direct (commit_direct),
        .triangle_ic (triangle_ic)
    );

endmodule

//--- verif/tri_mem_checker.sv
`timescale 1ns/10ps

module tri_mem_checker (
    input logic                  clk,
    input logic                  rst_n,
    input tri_pkg::mc_beat_t     mc_beat,
    input logic                  we_mc,
    input logic                  rdy_mc,
    input tri_pkg::load_state_e  load_state,
    input logic                  re_ic,
    input logic                  rdy_ic,
    input logic                  not_valid_ic
);

    import tri_pkg::*;

    int         fail_count = 0;
    logic       index_beat;
    logic       pending;
    logic [3:0] wait_cnt;

    // nonzero tag in the index phase starts a four word write
    assign index_beat = we_mc && rdy_mc && (mc_beat.tag != '0)
                        && (load_state == load_idle || load_state == load_index);

    // cycles spent on the open ic request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (re_ic) begin
            pending  <= 1'b1;
            wait_cnt <= '0;
        end else if (rdy_ic || not_valid_ic) begin
            pending <= 1'b0;
        end else if (pending) begin
            wait_cnt <= wait_cnt + 4'd1;
        end
    end

    a_answer_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rdy_ic && not_valid_ic))
        else begin
            $error("rdy_ic and not_valid_ic high together");
            fail_count++;
        end

    a_we_when_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        !(we_mc && !rdy_mc))
        else begin
            $error("we_mc high while rdy_mc low");
            fail_count++;
        end

    // still open at the eighth cycle means the answer is late
    a_answer_time: assert property (@(posedge clk) disable iff (!rst_n)
        (pending && !rdy_ic && !not_valid_ic) |-> (wait_cnt < 4'd7))
        else begin
            $error("ic request not answered within 8 cycles");
            fail_count++;
        end

    a_index_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(index_beat, 1) || $past(index_beat, 2) || $past(index_beat, 3)
         || $past(index_beat, 4)) |-> !rdy_mc)
        else begin
            $error("rdy_mc high during an index record write");
            fail_count++;
        end

    a_index_free: assert property (@(posedge clk) disable iff (!rst_n)
        $past(index_beat, 5) |-> rdy_mc)
        else begin
            $error("rdy_mc still low five cycles after an index beat");
            fail_count++;
        end

endmodule

//--- verif/tri_mem_tb.sv
`timescale 1ns/10ps

module tri_mem_tb;

    import tri_pkg::*;

    localparam int NUM_TRIANGLE = 64;
    localparam int ID_WIDTH     = $clog2(NUM_TRIANGLE);
    localparam int MAX_TRI      = 12;
    localparam int NUM_VERTEX   = 24;
    // tenfold margin over the roughly 600 cycles all tests take
    localparam int CYCLE_LIMIT  = 6000;

    logic                clk;
    logic                rst_n;
    mc_beat_t            mc_beat;
    logic                we_mc;
    logic                done_mc;
    logic                rdy_mc;
    logic                re_ic;
    logic [ID_WIDTH-1:0] tri_id;
    triangle_t           triangle_ic;
    logic                rdy_ic;
    logic                not_valid_ic;

    // scene model
    sid_t    sid_m [MAX_TRI];
    int      idx_m [MAX_TRI][3];
    vertex_t vert_m [NUM_VERTEX];
    int      num_tri;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int test_base;
    int cycles;
    int i;
    int id;

    tri_mem_top #(.NUM_TRIANGLE(NUM_TRIANGLE)) dut (
        .clk (clk), .rst_n (rst_n), .mc_beat (mc_beat), .we_mc (we_mc), .done_mc (done_mc),
        .rdy_mc (rdy_mc), .re_ic (re_ic), .tri_id (tri_id), .triangle_ic (triangle_ic),
        .rdy_ic (rdy_ic), .not_valid_ic (not_valid_ic)
    );

    bind tri_mem_top tri_mem_checker u_checker (
        .clk (clk), .rst_n (rst_n), .mc_beat (mc_beat), .we_mc (we_mc), .rdy_mc (rdy_mc),
        .load_state (u_load.state), .re_ic (re_ic), .rdy_ic (rdy_ic),
        .not_valid_ic (not_valid_ic)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int total_failures();
        return errors + dut.u_checker.fail_count;
    endfunction

    function automatic triangle_t expected_tri(input int n);
        triangle_t t;
        t.sid = sid_m[n];
        t.v0  = vert_m[idx_m[n][0]];
        t.v1  = vert_m[idx_m[n][1]];
        t.v2  = vert_m[idx_m[n][2]];
        return t;
    endfunction

    task automatic make_scene(input int n);
        int t;
        int k;
        num_tri = n;
        for (t = 0; t < n; t++) begin
            sid_m[t] = $random(seed) | 32'h1;
            for (k = 0; k < 3; k++) begin
                idx_m[t][k] = $unsigned($random(seed)) % NUM_VERTEX;
            end
        end
        for (t = 0; t < NUM_VERTEX; t++) begin
            vert_m[t].x = $random(seed);
            vert_m[t].y = $random(seed);
            vert_m[t].z = $random(seed);
        end
    endtask

    // called 1 ns after a rising edge and returns at the same point
    task automatic send_beat(input mc_beat_t b);
        while (!rdy_mc) begin
            @(posedge clk);
            #1;
        end
        mc_beat = b;
        we_mc   = 1'b1;
        @(posedge clk);
        #1;
        we_mc = 1'b0;
    endtask

    task automatic load_scene();
        mc_beat_t b;
        int       t;
        for (t = 0; t < num_tri; t++) begin
            b = '{tag: sid_m[t], w2: idx_m[t][2], w1: idx_m[t][1], w0: idx_m[t][0]};
            send_beat(b);
        end
        // zero tag switches to vertex records
        send_beat('0);
        for (t = 0; t < NUM_VERTEX; t++) begin
            b = '{tag: 32'h1, w2: vert_m[t].z, w1: vert_m[t].y, w0: vert_m[t].x};
            send_beat(b);
        end
        send_beat('0);
        assert (dut.u_load.loading) else begin
            $display("loader left the load before done_mc");
            errors++;
        end
        done_mc = 1'b1;
        @(posedge clk);
        #1;
        done_mc = 1'b0;
    endtask

    task automatic request(input int n, output int lat);
        tri_id = n[ID_WIDTH-1:0];
        re_ic  = 1'b1;
        @(posedge clk);
        #1;
        re_ic = 1'b0;
        lat   = 1;
        while (!rdy_ic && !not_valid_ic && lat < 20) begin
            @(posedge clk);
            #1;
            lat++;
        end
    endtask

    task automatic check_read(input int n, input int max_lat);
        triangle_t exp;
        int        lat;
        exp = expected_tri(n);
        request(n, lat);
        if (!rdy_ic && !not_valid_ic) begin
            $display("request for id %0d got no answer", n);
            errors++;
        end else begin
            assert (rdy_ic) else begin
                $display("FAIL rdy_ic id %0d got %h exp %h", n, rdy_ic, 1'b1);
                errors++;
            end
            assert (lat <= max_lat) else begin
                $display("FAIL rdy_ic delay id %0d got %h exp %h", n, lat, max_lat);
                errors++;
            end
            assert (triangle_ic.sid == exp.sid) else begin
                $display("FAIL triangle_ic.sid id %0d got %h exp %h", n, triangle_ic.sid, exp.sid);
                errors++;
            end
            assert (triangle_ic.v0 == exp.v0) else begin
                $display("FAIL triangle_ic.v0 id %0d got %h exp %h", n, triangle_ic.v0, exp.v0);
                errors++;
            end
            assert (triangle_ic.v1 == exp.v1) else begin
                $display("FAIL triangle_ic.v1 id %0d got %h exp %h", n, triangle_ic.v1, exp.v1);
                errors++;
            end
            assert (triangle_ic.v2 == exp.v2) else begin
                $display("FAIL triangle_ic.v2 id %0d got %h exp %h", n, triangle_ic.v2, exp.v2);
                errors++;
            end
        end
    endtask

    task automatic check_invalid(input int n);
        int lat;
        request(n, lat);
        assert (not_valid_ic && !rdy_ic) else begin
            $display("FAIL not_valid_ic id %0d got %h exp %h", n, not_valid_ic, 1'b1);
            errors++;
        end
        assert (lat == 1) else begin
            $display("FAIL not_valid_ic delay id %0d got %h exp %h", n, lat, 1);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic begin_test();
        test_base = total_failures();
    endtask

    task automatic end_test(input string name);
        int failed_now;
        failed_now = total_failures() - test_base;
        tests_run++;
        if (failed_now == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failed checks", tests_run, name, failed_now);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run stopped after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h15b5dbca;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        num_tri      = 0;
        rst_n        = 1'b0;
        mc_beat      = '0;
        we_mc        = 1'b0;
        done_mc      = 1'b0;
        re_ic        = 1'b0;
        tri_id       = '0;
        idle(16);
        rst_n = 1'b1;
        idle(2);

        begin_test();
        assert (rdy_mc) else begin
            $display("FAIL rdy_mc got %h exp %h", rdy_mc, 1'b1);
            errors++;
        end
        check_invalid(0);
        end_test("reset state");

        begin_test();
        make_scene(MAX_TRI);
        load_scene();
        assert (!dut.u_load.loading && rdy_mc) else begin
            $display("loader did not return to idle after done_mc");
            errors++;
        end
        end_test("scene load");

        begin_test();
        for (i = 0; i < num_tri; i++) begin
            check_read(i, (i == 0) ? 8 : 1);
            // room for the prefetch of the next id
            idle(8);
        end
        end_test("sequential read");

        begin_test();
        for (i = 0; i < 24; i++) begin
            id = $unsigned($random(seed)) % num_tri;
            check_read(id, 8);
        end
        end_test("random read");

        begin_test();
        check_invalid(12);
        check_invalid(63);
        check_read(3, 8);
        end_test("out of range");

        begin_test();
        idle(4);
        make_scene(5);
        load_scene();
        check_invalid(7);
        for (i = 0; i < num_tri; i++) begin
            check_read(i, 8);
        end
        end_test("reload");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_failures());
        if (total_failures() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tri_mem_top.f
hw/tri_pkg.sv
hw/tri_ram.sv
hw/load_addr_counter.sv
hw/tri_store.sv
hw/tri_load_fsm.sv
hw/tri_fetch_fsm.sv
hw/tri_out_buffer.sv
hw/tri_mem_top.sv
verif/tri_mem_checker.sv
verif/tri_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tri_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tri_mem_tb --Mdir "$OBJ_DIR" -o tri_mem_sim \
    -f tri_mem_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# error limit raised so a run with assertion errors still reaches the end of the testbench
"./$OBJ_DIR/tri_mem_sim" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
